/* bru_sub.f */
+incdir+source
source/bru_pkg.sv
source/bru_decode.sv
source/bru_execute.sv
source/bru_result.sv
source/bru_top.sv
tb/bru_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the branch resolution unit testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module bru_tb -Mdir obj_dir -f bru_sub.f

./obj_dir/Vbru_tb | tee sim.log

if grep -qx '>>> PASS' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb/bru_tb.sv */
// branch resolution unit testbench
// lcg-driven requests over the four-phase handshake, expected outcome
// from a reference model of the redirect rules, checked by assertions
`timescale 1ns/1ps
`include "bru_settings.svh"

module bru_tb import bru_pkg::*; ();
    localparam int K_ADDI  = 9;   // non-branch kinds, after BJP_FENCE
    localparam int K_LOAD  = 10;
    localparam int N_SHORT = 89;  // requests with hold 0..3
    localparam int N_LONG  = 6;   // requests with hold 8..23
    localparam int TIMEOUT_CYCLES = N_SHORT * 16 + N_LONG * 32 + 100;

    logic  clk;
    logic  arst_n_i;
    logic  req_i;
    inst_t inst_i;
    addr_t pc_i;
    word_t rs1_i;
    word_t rs2_i;
    logic  pred_taken_i;
    addr_t pred_addr_i;
    logic  int_assert_i;
    addr_t int_addr_i;
    logic  ack_o;
    logic  redirect_o;
    addr_t redirect_addr_o;
    logic  link_wr_o;
    word_t link_data_o;

    logic [31:0] seed;
    logic  exp_redirect;      // model outcome for the request in flight
    addr_t exp_raddr;
    logic  exp_link_wr;
    word_t exp_ldata;
    int    errors = 0;
    int    n_req  = 0;
    int    n_ack  = 0;
    int    cycles = 0;
    logic  ack_q  = 1'b0;

    bru_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int short_hold();
        return int'(rand32() & 32'd3);
    endfunction

    function automatic logic [2:0] f3_of(input int kind);
        case (kind)
            BJP_BNE:  return `F3_BNE;
            BJP_BLT:  return `F3_BLT;
            BJP_BGE:  return `F3_BGE;
            BJP_BLTU: return `F3_BLTU;
            BJP_BGEU: return `F3_BGEU;
            default:  return `F3_BEQ;
        endcase
    endfunction

    // rs1 = x1, rs2 = x2, rd = x1
    function automatic inst_t enc_branch(input logic [2:0] f3, input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic inst_t enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `OPC_JAL};
    endfunction

    function automatic inst_t enc_itype(input logic [6:0] opc, input logic [11:0] imm);
        return {imm, 5'd1, 3'b000, 5'd1, opc};
    endfunction

    // expected outcome straight from the resolution rules
    function automatic void resolve(input int kind, input word_t imm, input addr_t pc,
                                    input word_t a, input word_t b, input logic pt,
                                    input addr_t pa, input logic irq, input addr_t ia);
        logic  taken;
        addr_t tgt;
        taken = 1'b0;
        tgt   = (a + imm) & ~32'd1;  // jalr target, bit 0 dropped
        case (kind)
            BJP_BEQ:  taken = (a == b);
            BJP_BNE:  taken = (a != b);
            BJP_BLT:  taken = ($signed(a) < $signed(b));
            BJP_BGE:  taken = ($signed(a) >= $signed(b));
            BJP_BLTU: taken = (a < b);
            BJP_BGEU: taken = (a >= b);
            default:  taken = 1'b0;
        endcase
        exp_redirect = 1'b0;
        exp_raddr    = '0;
        exp_link_wr  = 1'b0;
        exp_ldata    = pc + 32'd4;
        if (kind <= BJP_BGEU) begin
            if (taken != pt) begin  // missed target or rollback
                exp_redirect = 1'b1;
                exp_raddr    = taken ? pc + imm : pc + 32'd4;
            end
        end else if (kind == BJP_JAL) begin
            exp_link_wr  = 1'b1;
            exp_redirect = !pt;
            exp_raddr    = pc + imm;
        end else if (kind == BJP_JALR) begin
            exp_link_wr  = 1'b1;
            exp_redirect = !pt || (pa != tgt);
            exp_raddr    = tgt;
        end else if (kind == BJP_FENCE) begin
            exp_redirect = 1'b1;
            exp_raddr    = pc + 32'd4;
        end
        if (irq) begin  // interrupt overrides everything
            exp_redirect = 1'b1;
            exp_raddr    = ia;
            exp_link_wr  = 1'b0;
        end
    endfunction

    // one full four-phase transaction, entered and left on a rising edge
    task automatic send(input int kind, input word_t a, input word_t b, input logic pt,
                        input logic wrong_pa, input logic irq, input int hold);
        word_t r;
        word_t imm;
        addr_t pc;
        addr_t pa;
        addr_t ia;
        inst_t inst;
        r  = rand32();
        pc = rand32() & ~32'd3;
        ia = rand32() & ~32'd3;
        case (kind)
            BJP_JAL: begin
                imm  = {{11{r[19]}}, r[19:0], 1'b0};
                inst = enc_jal(imm[20:0]);
            end
            BJP_JALR: begin
                imm  = {{20{r[11]}}, r[11:0]};
                inst = enc_itype(`OPC_JALR, imm[11:0]);
            end
            BJP_FENCE: begin
                imm  = '0;
                inst = enc_itype(`OPC_FENCE, 12'd0);
            end
            K_ADDI, K_LOAD: begin
                imm  = {{20{r[11]}}, r[11:0]};
                inst = enc_itype((kind == K_LOAD) ? 7'b0000011 : 7'b0010011, imm[11:0]);
            end
            default: begin  // conditional branches
                imm  = {{19{r[11]}}, r[11:0], 1'b0};
                inst = enc_branch(f3_of(kind), imm[12:0]);
            end
        endcase
        pa = (kind == BJP_JALR) ? ((a + imm) & ~32'd1) : pc + imm;  // where fetch went
        if (wrong_pa)
            pa = pa ^ 32'h40;
        inst_i       <= inst;
        pc_i         <= pc;
        rs1_i        <= a;
        rs2_i        <= b;
        pred_taken_i <= pt;
        pred_addr_i  <= pa;
        int_assert_i <= irq;
        int_addr_i   <= ia;
        req_i        <= 1'b1;
        resolve(kind, imm, pc, a, b, pt, pa, irq, ia);  // latched with the rising req
        n_req++;
        @(posedge clk);
        while (!ack_o) @(posedge clk);
        repeat (hold) @(posedge clk);  // back-pressure, ack and outcome held
        req_i <= 1'b0;
        @(posedge clk);
        while (ack_o) @(posedge clk);
    endtask

    task automatic report(input string name, input int e0, input int n0);
        $display("test %s: %0d requests, %0d errors", name, n_req - n0, errors - e0);
    endtask

    // outcome vs model on every ack cycle, so also held stable
    assert property (@(posedge clk) disable iff (!arst_n_i) ack_o |-> redirect_o == exp_redirect)
        else begin
            errors++;
            $display("ERROR %0t redirect_o got %0b expected %0b", $time, redirect_o, exp_redirect);
        end
    assert property (@(posedge clk) disable iff (!arst_n_i)
        ack_o && exp_redirect |-> redirect_addr_o == exp_raddr)
        else begin
            errors++;
            $display("ERROR %0t redirect_addr_o got %h expected %h", $time, redirect_addr_o,
                     exp_raddr);
        end
    assert property (@(posedge clk) disable iff (!arst_n_i) ack_o |-> link_wr_o == exp_link_wr)
        else begin
            errors++;
            $display("ERROR %0t link_wr_o got %0b expected %0b", $time, link_wr_o, exp_link_wr);
        end
    assert property (@(posedge clk) disable iff (!arst_n_i)
        ack_o && exp_link_wr |-> link_data_o == exp_ldata)
        else begin
            errors++;
            $display("ERROR %0t link_data_o got %h expected %h", $time, link_data_o, exp_ldata);
        end

    // handshake timing, req seen at N gives ack sampled high at N+3
    assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(ack_o) |-> $past(req_i, 3) && !$past(req_i, 4))
        else begin
            errors++;
            $display("ack_o rose at %0t but not two edges after a new req_i", $time);
        end
    assert property (@(posedge clk) disable iff (!arst_n_i) ack_o && req_i |=> ack_o)
        else begin
            errors++;
            $display("ack_o dropped at %0t while req_i was still held", $time);
        end
    assert property (@(posedge clk) disable iff (!arst_n_i) ack_o && !req_i |=> !ack_o)
        else begin
            errors++;
            $display("ack_o still high at %0t one edge after req_i dropped", $time);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        ack_q  <= ack_o;
        if (ack_o && !ack_q)
            n_ack <= n_ack + 1;  // ack rising edges
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout, run still going after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int    e0;
        int    n0;
        word_t a;
        word_t b;
        seed         = 32'hccfc;
        arst_n_i     = 1'b0;
        req_i        = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        rs1_i        = '0;
        rs2_i        = '0;
        pred_taken_i = 1'b0;
        pred_addr_i  = '0;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);
        assert (!ack_o && !redirect_o && !link_wr_o)
            else begin
                errors++;
                $display("ERROR %0t ack_o/redirect_o/link_wr_o got %b%b%b expected 000",
                         $time, ack_o, redirect_o, link_wr_o);
            end

        e0 = errors;
        n0 = n_req;
        for (int k = 0; k < 6; k++)
            for (int p = 0; p < 2; p++)
                for (int c = 0; c < 4; c++) begin
                    a = rand32();
                    b = rand32();
                    if (c == 1)
                        b = a;  // equal operands
                    if (c == 2) begin
                        a[31] = 1'b1;  // sign bits differ both ways
                        b[31] = 1'b0;
                    end
                    if (c == 3) begin
                        a[31] = 1'b0;
                        b[31] = 1'b1;
                    end
                    send(k, a, b, p[0], 1'b0, 1'b0, short_hold());
                end
        report("conditional branches", e0, n0);

        e0 = errors;
        n0 = n_req;
        for (int i = 0; i < 8; i++)
            send(BJP_JAL, rand32(), rand32(), i[0], 1'b0, 1'b0, short_hold());
        for (int i = 0; i < 12; i++)  // not predicted, right address, wrong address
            send(BJP_JALR, rand32(), rand32(), i % 3 != 0, i % 3 == 2, 1'b0, short_hold());
        report("jal and jalr", e0, n0);

        e0 = errors;
        n0 = n_req;
        for (int i = 0; i < 9; i++)
            send((i < 3) ? BJP_FENCE : ((i < 6) ? K_ADDI : K_LOAD), rand32(), rand32(),
                 i[0], 1'b0, 1'b0, short_hold());
        report("fence and non-branch", e0, n0);

        e0 = errors;
        n0 = n_req;
        for (int i = 0; i < 12; i++)
            send(int'(rand32() % 32'd11), rand32(), rand32(), i[0], i[1], 1'b1, short_hold());
        report("interrupt override", e0, n0);

        e0 = errors;
        n0 = n_req;
        for (int i = 0; i < 6; i++)  // long holds, then back to back
            send(int'(rand32() % 32'd11), rand32(), rand32(), i[0], 1'b0, 1'b0,
                 8 + int'(rand32() & 32'd15));
        assert (n_ack == n_req)
            else begin
                errors++;
                $display("%0d requests drew %0d acks", n_req, n_ack);
            end
        report("handshake", e0, n0);

        $display("summary: %0d requests, %0d acks, %0d errors", n_req, n_ack, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* source/bru_top.sv */
// branch resolution unit top
// decode -> execute -> result, one instruction in flight,
// four-phase req/ack toward the requester
`timescale 1ns/1ps

module bru_top import bru_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  req_i,
    input  inst_t inst_i,
    input  addr_t pc_i,
    input  word_t rs1_i,
    input  word_t rs2_i,
    input  logic  pred_taken_i,   // fetch already followed this target
    input  addr_t pred_addr_i,    // predicted jalr target
    input  logic  int_assert_i,
    input  addr_t int_addr_i,
    output logic  ack_o,
    output logic  redirect_o,
    output addr_t redirect_addr_o,
    output logic  link_wr_o,
    output word_t link_data_o
);
    logic    launch;
    logic    dec_valid;
    bjp_op_t bjp_op;
    word_t   cmp_op1;
    word_t   cmp_op2;
    word_t   jump_op1;
    word_t   jump_op2;
    addr_t   dec_pc;
    logic    dec_pred_taken;
    addr_t   dec_pred_addr;
    logic    dec_int_assert;
    addr_t   dec_int_addr;
    logic    exe_valid;
    logic    exe_redirect;
    addr_t   exe_redirect_addr;
    logic    exe_link_wr;
    word_t   exe_link_data;

    bru_decode u_decode (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .launch_i     (launch),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .pred_taken_i (pred_taken_i),
        .pred_addr_i  (pred_addr_i),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .valid_o      (dec_valid),
        .bjp_op_o     (bjp_op),
        .cmp_op1_o    (cmp_op1),
        .cmp_op2_o    (cmp_op2),
        .jump_op1_o   (jump_op1),
        .jump_op2_o   (jump_op2),
        .pc_o         (dec_pc),
        .pred_taken_o (dec_pred_taken),
        .pred_addr_o  (dec_pred_addr),
        .int_assert_o (dec_int_assert),
        .int_addr_o   (dec_int_addr)
    );

    bru_execute u_execute (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .valid_i         (dec_valid),
        .bjp_op_i        (bjp_op),
        .cmp_op1_i       (cmp_op1),
        .cmp_op2_i       (cmp_op2),
        .jump_op1_i      (jump_op1),
        .jump_op2_i      (jump_op2),
        .pc_i            (dec_pc),
        .pred_taken_i    (dec_pred_taken),
        .pred_addr_i     (dec_pred_addr),
        .int_assert_i    (dec_int_assert),
        .int_addr_i      (dec_int_addr),
        .valid_o         (exe_valid),
        .redirect_o      (exe_redirect),
        .redirect_addr_o (exe_redirect_addr),
        .link_wr_o       (exe_link_wr),
        .link_data_o     (exe_link_data)
    );

    bru_result u_result (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .req_i           (req_i),
        .valid_i         (exe_valid),
        .redirect_i      (exe_redirect),
        .redirect_addr_i (exe_redirect_addr),
        .link_wr_i       (exe_link_wr),
        .link_data_i     (exe_link_data),
        .launch_o        (launch),
        .ack_o           (ack_o),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o),
        .link_wr_o       (link_wr_o),
        .link_data_o     (link_data_o)
    );

endmodule

/* source/bru_result.sv */
// branch resolution unit, result stage
// four-phase req/ack fsm, launches decode and holds the outcome
// stable on the outputs for as long as ack is high
`timescale 1ns/1ps

module bru_result import bru_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  req_i,
    input  logic  valid_i,          // outcome ready from execute
    input  logic  redirect_i,
    input  addr_t redirect_addr_i,
    input  logic  link_wr_i,
    input  word_t link_data_i,
    output logic  launch_o,
    output logic  ack_o,
    output logic  redirect_o,
    output addr_t redirect_addr_o,
    output logic  link_wr_o,
    output word_t link_data_o
);
    hs_state_t state_q;
    hs_state_t state_d;
    logic      capture;

    assign launch_o = (state_q == HS_IDLE) & req_i;  // decode samples this edge
    assign capture  = (state_q == HS_BUSY) & valid_i;
    assign ack_o    = (state_q == HS_ACK);

    always_comb begin
        state_d = state_q;
        case (state_q)
            HS_IDLE: begin
                if (req_i) state_d = HS_BUSY;
            end
            HS_BUSY: begin
                if (valid_i) state_d = HS_ACK;  // two edges after launch
            end
            HS_ACK: begin
                if (!req_i) state_d = HS_IDLE;  // requester released
            end
            default: state_d = HS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= HS_IDLE;
            redirect_o <= 1'b0;
            link_wr_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (capture) begin
                redirect_o <= redirect_i;
                link_wr_o  <= link_wr_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            redirect_addr_o <= redirect_addr_i;
            link_data_o     <= link_data_i;
        end
    end

    // ack only answers a request still being held
    assert property (@(posedge clk) disable iff (!arst_n_i) $rose(ack_o) |-> req_i);

    // outcome frozen during ack
    assert property (@(posedge clk) disable iff (!arst_n_i)
        ack_o && $past(ack_o) |-> $stable({redirect_o, redirect_addr_o, link_wr_o, link_data_o}));

endmodule

/* source/bru_execute.sv */
// branch resolution unit, execute stage
// resolves the branch condition, computes target or rollback address
// on one shared adder, applies the redirect rules and registers them
`timescale 1ns/1ps
`include "bru_settings.svh"

module bru_execute import bru_pkg::*; (
    input  logic    clk,
    input  logic    arst_n_i,
    input  logic    valid_i,
    input  bjp_op_t bjp_op_i,
    input  word_t   cmp_op1_i,
    input  word_t   cmp_op2_i,
    input  word_t   jump_op1_i,
    input  word_t   jump_op2_i,
    input  addr_t   pc_i,
    input  logic    pred_taken_i,
    input  addr_t   pred_addr_i,
    input  logic    int_assert_i,
    input  addr_t   int_addr_i,
    output logic    valid_o,
    output logic    redirect_o,
    output addr_t   redirect_addr_o,
    output logic    link_wr_o,
    output word_t   link_data_o
);
    logic  op1_eq_op2;
    logic  op1_ge_op2_s;
    logic  op1_ge_op2_u;
    logic  is_branch;
    logic  branch_cond;
    logic  rollback;
    logic  use_pc4;
    addr_t adder_op1;
    addr_t adder_op2;
    addr_t adder_res;
    addr_t target;
    logic  addr_mismatch;
    logic  redirect_d;
    addr_t link_pc;

    // one comparison set covers all six conditions
    assign op1_eq_op2   = (cmp_op1_i == cmp_op2_i);
    assign op1_ge_op2_s = $signed(cmp_op1_i) >= $signed(cmp_op2_i);
    assign op1_ge_op2_u = cmp_op1_i >= cmp_op2_i;

    assign is_branch = |bjp_op_i[BJP_BGEU:BJP_BEQ];

    assign branch_cond = (bjp_op_i[BJP_BEQ]  &  op1_eq_op2)   |
                         (bjp_op_i[BJP_BNE]  & ~op1_eq_op2)   |
                         (bjp_op_i[BJP_BLT]  & ~op1_ge_op2_s) |
                         (bjp_op_i[BJP_BGE]  &  op1_ge_op2_s) |
                         (bjp_op_i[BJP_BLTU] & ~op1_ge_op2_u) |
                         (bjp_op_i[BJP_BGEU] &  op1_ge_op2_u);

    // front end went to the target, branch falls through
    assign rollback = is_branch & pred_taken_i & ~branch_cond;
    assign use_pc4  = rollback | bjp_op_i[BJP_FENCE];  // refetch next inst

    // shared adder, pc + 4 or base + offset
    assign adder_op1 = use_pc4 ? pc_i : jump_op1_i;
    assign adder_op2 = use_pc4 ? addr_t'(4) : jump_op2_i;
    assign adder_res = adder_op1 + adder_op2;

    // jalr clears bit 0
    assign target = bjp_op_i[BJP_JALR] ? {adder_res[`INST_ADDR_WIDTH-1:1], 1'b0} : adder_res;

    assign addr_mismatch = pred_taken_i & (target != pred_addr_i);  // jalr only

    assign redirect_d = int_assert_i                                   |
                        (branch_cond & ~pred_taken_i)                  |
                        rollback                                       |
                        (bjp_op_i[BJP_JAL] & ~pred_taken_i)            |
                        (bjp_op_i[BJP_JALR] & (~pred_taken_i | addr_mismatch)) |
                        bjp_op_i[BJP_FENCE];

    assign link_pc = pc_i + addr_t'(4);  // own incrementer for the link value

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o    <= 1'b0;
            redirect_o <= 1'b0;
            link_wr_o  <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                redirect_o <= redirect_d;
                // interrupt suppresses the jump writeback
                link_wr_o  <= ~int_assert_i & (bjp_op_i[BJP_JAL] | bjp_op_i[BJP_JALR]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            redirect_addr_o <= int_assert_i ? int_addr_i : target;  // interrupt wins
            link_data_o     <= link_pc;
        end
    end

    // a jalr redirect never leaves with an odd address
    assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_i && bjp_op_i[BJP_JALR] && !int_assert_i |=> !redirect_o || !redirect_addr_o[0]);

endmodule

/* source/bru_decode.sv */
// branch resolution unit decode stage
// captures a launched instruction with its operands, decodes the
// branch op one-hot and prepares base + offset for the target adder
`timescale 1ns/1ps
`include "bru_settings.svh"

module bru_decode import bru_pkg::*; (
    input  logic    clk,
    input  logic    arst_n_i,
    input  logic    launch_i,      // one-cycle pulse from result
    input  inst_t   inst_i,
    input  addr_t   pc_i,
    input  word_t   rs1_i,
    input  word_t   rs2_i,
    input  logic    pred_taken_i,
    input  addr_t   pred_addr_i,
    input  logic    int_assert_i,
    input  addr_t   int_addr_i,
    output logic    valid_o,
    output bjp_op_t bjp_op_o,
    output word_t   cmp_op1_o,
    output word_t   cmp_op2_o,
    output word_t   jump_op1_o,    // rs1 for jalr, pc otherwise
    output word_t   jump_op2_o,    // immediate
    output addr_t   pc_o,
    output logic    pred_taken_o,
    output addr_t   pred_addr_o,
    output logic    int_assert_o,
    output addr_t   int_addr_o
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_i;
    bjp_op_t    op_d;
    word_t      jump_base;
    word_t      jump_off;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    // immediates all sign extended from inst[31]
    assign imm_b = {{(`XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{(`XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_i = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};  // jalr

    always_comb begin
        op_d = '0;  // non-branch passes through as zero
        case (opcode)
            `OPC_BRANCH: begin
                case (funct3)
                    `F3_BEQ:  op_d[BJP_BEQ]  = 1'b1;
                    `F3_BNE:  op_d[BJP_BNE]  = 1'b1;
                    `F3_BLT:  op_d[BJP_BLT]  = 1'b1;
                    `F3_BGE:  op_d[BJP_BGE]  = 1'b1;
                    `F3_BLTU: op_d[BJP_BLTU] = 1'b1;
                    `F3_BGEU: op_d[BJP_BGEU] = 1'b1;
                    default:  op_d = '0;      // reserved funct3
                endcase
            end
            `OPC_JAL:   op_d[BJP_JAL]   = 1'b1;
            `OPC_JALR:  op_d[BJP_JALR]  = 1'b1;
            `OPC_FENCE: op_d[BJP_FENCE] = 1'b1;
            default:    op_d = '0;
        endcase
    end

    // execute only ever sees base + offset
    assign jump_base = op_d[BJP_JALR] ? rs1_i : pc_i;
    assign jump_off  = (opcode == `OPC_BRANCH) ? imm_b :
                       (opcode == `OPC_JAL)    ? imm_j : imm_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= launch_i;  // single-cycle valid into execute
        end
    end

    // payload only written on launch
    always_ff @(posedge clk) begin
        if (launch_i) begin
            bjp_op_o     <= op_d;
            cmp_op1_o    <= rs1_i;
            cmp_op2_o    <= rs2_i;
            jump_op1_o   <= jump_base;
            jump_op2_o   <= jump_off;
            pc_o         <= pc_i;
            pred_taken_o <= pred_taken_i;
            pred_addr_o  <= pred_addr_i;
            int_assert_o <= int_assert_i;
            int_addr_o   <= int_addr_i;
        end
    end

    // op vector one-hot or zero while valid
    assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_o |-> $onehot0(bjp_op_o));

endmodule

/* source/bru_pkg.sv */
// branch resolution unit types
// vector typedefs, branch op bit positions, handshake fsm states
`include "bru_settings.svh"

package bru_pkg;

    typedef logic [`XLEN-1:0]            word_t;  // register values, immediates
    typedef logic [`INST_ADDR_WIDTH-1:0] addr_t;  // pcs and targets
    typedef logic [31:0]                 inst_t;  // raw instruction word

    // one-hot, or zero for anything that is not a branch or jump
    typedef logic [`BJP_OP_W-1:0] bjp_op_t;

    // bit positions inside bjp_op_t
    localparam int unsigned BJP_BEQ   = 0;
    localparam int unsigned BJP_BNE   = 1;
    localparam int unsigned BJP_BLT   = 2;
    localparam int unsigned BJP_BGE   = 3;
    localparam int unsigned BJP_BLTU  = 4;
    localparam int unsigned BJP_BGEU  = 5;
    localparam int unsigned BJP_JAL   = 6;
    localparam int unsigned BJP_JALR  = 7;
    localparam int unsigned BJP_FENCE = 8;

    // four-phase req/ack sequencing
    typedef enum logic [1:0] {
        HS_IDLE = 2'd0,  // waiting for req
        HS_BUSY = 2'd1,  // instruction in decode/execute
        HS_ACK  = 2'd2   // outcome held, ack high
    } hs_state_t;

endpackage

/* source/bru_settings.svh */
// branch resolution unit settings
// data and address widths, riscv opcode and funct3 codes
`ifndef BRU_SETTINGS_SVH
`define BRU_SETTINGS_SVH

`define XLEN             32
`define INST_ADDR_WIDTH  32

// major opcodes, inst[6:0]
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_FENCE   7'b0001111  // fence and fence.i share it

// conditional branch funct3, inst[14:12]
`define F3_BEQ   3'b000
`define F3_BNE   3'b001
`define F3_BLT   3'b100
`define F3_BGE   3'b101
`define F3_BLTU  3'b110
`define F3_BGEU  3'b111

`define BJP_OP_W  9  // six branches, jal, jalr, fence
`endif
